//--- Makefile
# Verilator build and run for the SDRAM command scheduler

VERILATOR ?= verilator
TOP       ?= sdram_sched_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= PASS: all tests

BIN     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard source/*.sv tests/*.sv include/*.svh)

.PHONY: all run lint clean

all: run

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$($(BIN) $(SIM_ARGS))"; echo "$$out"; echo "$$out" | grep -qx '$(PASS_MSG)'

lint:
	$(VERILATOR) --lint-only -Wall --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- include/sdram_timing_macros.svh
// SDRAM scheduler constants
// Device geometry, bank timings in clock cycles and refresh control
`ifndef SDRAM_TIMING_MACROS_SVH
`define SDRAM_TIMING_MACROS_SVH

// Device geometry
`define SDRAM_BANKS        4
`define SDRAM_BA_W         2
`define SDRAM_ROW_W        13
`define SDRAM_COL_W        10
`define SDRAM_DQ_W         16

// Bank timer reload values
`define SDRAM_T_RCD        3
`define SDRAM_T_RAS        6
`define SDRAM_T_RP         3
`define SDRAM_T_RC         8
`define SDRAM_TMR_W        4

// Read latency and refresh
`define SDRAM_CL           2
`define SDRAM_T_REFI       200
`define SDRAM_REF_PEND_MAX 7

`endif

//--- source/bank_if.sv
// Bank status and command link
// Carries the issued command to the tracker and bank state back to the FSM
`timescale 1ns/10ps
`include "sdram_timing_macros.svh"

interface bank_if
  import sdram_dev_pkg::*;
();

  // Command being registered to the pins, row carries the full address
  sdram_cmd_e              cmd;
  ba_t                     ba;
  row_t                    row;

  // Per bank status
  logic [`SDRAM_BANKS-1:0] bank_open;
  row_t                    open_row [`SDRAM_BANKS];
  logic [`SDRAM_BANKS-1:0] rcd_done;
  logic [`SDRAM_BANKS-1:0] ras_done;
  logic [`SDRAM_BANKS-1:0] rp_done;
  logic                    rc_done;

  modport tracker (
    input  cmd, ba, row,
    output bank_open, open_row, rcd_done, ras_done, rp_done, rc_done
  );

  modport fsm (
    output cmd, ba, row,
    input  bank_open, open_row, rcd_done, ras_done, rp_done, rc_done
  );

endinterface

//--- source/bank_tracker.sv
// Bank tracker
// Open row table per bank with tRCD, tRAS and tRP timers
// and one shared tRC timer
`timescale 1ns/10ps
`include "sdram_timing_macros.svh"

module bank_tracker
  import sdram_dev_pkg::*;
  import sdram_host_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_ni,
  bank_if.tracker bank
);

  localparam int NB  = `SDRAM_BANKS;
  // Timer slots: tRCD per bank, tRAS per bank, tRP per bank, then tRC
  localparam int NT  = 3*NB + 1;
  localparam int A10 = 10;

  logic [NB-1:0] open_q;
  logic [NB-1:0] open_set;
  logic [NB-1:0] open_clr;
  row_t          open_row_q [NB];
  logic [NT-1:0] load;
  logic [NT-1:0] done_q;
  tmr_t          cnt_q [NT];

  function automatic tmr_t reload_val(input int idx);
    tmr_t val;
    if (idx < NB)
      val = tmr_t'(`SDRAM_T_RCD);
    else if (idx < 2*NB)
      val = tmr_t'(`SDRAM_T_RAS);
    else if (idx < 3*NB)
      val = tmr_t'(`SDRAM_T_RP);
    else
      val = tmr_t'(`SDRAM_T_RC);
    return val;
  endfunction

  //////////////////////////////////////////////////
  // Command decode
  //////////////////////////////////////////////////
  always_comb
  begin
    load     = '0;
    open_set = '0;
    open_clr = '0;
    case (bank.cmd)
      ACT:
      begin
        load[bank.ba]      = 1'b1;
        load[NB + bank.ba] = 1'b1;
        open_set[bank.ba]  = 1'b1;
      end
      PRE:
        // A10 selects all banks
        if (bank.row[A10])
        begin
          load[3*NB-1:2*NB] = '1;
          open_clr          = '1;
        end
        else
        begin
          load[2*NB + bank.ba] = 1'b1;
          open_clr[bank.ba]    = 1'b1;
        end
      REF:     load[3*NB] = 1'b1;
      default: ;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      open_q <= '0;
    else
      open_q <= (open_q & ~open_clr) | open_set;
  end

  always_ff @(posedge clk_i)
  begin
    if (bank.cmd == ACT)
      open_row_q[bank.ba] <= bank.row;
  end

  //////////////////////////////////////////////////
  // Down counters, done flag set when count runs out
  //////////////////////////////////////////////////
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      for (int i = 0; i < NT; i++)
      begin
        cnt_q[i]  <= '0;
        done_q[i] <= 1'b1;
      end
    end
    else
    begin
      for (int i = 0; i < NT; i++)
      begin
        if (load[i])
        begin
          cnt_q[i]  <= reload_val(i);
          done_q[i] <= (reload_val(i) == '0);
        end
        else if (!done_q[i])
        begin
          cnt_q[i]  <= cnt_q[i] - 1'b1;
          done_q[i] <= (cnt_q[i] == tmr_t'(1));
        end
      end
    end
  end

  assign bank.bank_open = open_q;
  assign bank.open_row  = open_row_q;
  assign bank.rcd_done  = done_q[NB-1:0];
  assign bank.ras_done  = done_q[2*NB-1:NB];
  assign bank.rp_done   = done_q[3*NB-1:2*NB];
  assign bank.rc_done   = done_q[3*NB];

endmodule

//--- source/cmd_fsm.sv
// SDRAM command FSM
// Picks refresh, ACT, PRE, RD or WR each cycle from bank status
// and registers the command, address and write data to the pins
`timescale 1ns/10ps

module cmd_fsm
  import sdram_dev_pkg::*;
  import sdram_host_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,

  // Host request
  input  logic       req_i,
  input  logic       we_i,
  input  ba_t        ba_i,
  input  row_t       row_i,
  input  col_t       col_i,
  input  dq_t        wdata_i,
  output logic       ack_o,

  // Refresh
  input  logic       ref_pending_i,
  output logic       ref_issued_o,

  bank_if.fsm        bank,

  // SDRAM pins
  output sdram_cmd_e sdram_cmd_o,
  output ba_t        sdram_ba_o,
  output addr_t      sdram_addr_o,
  output dq_t        sdram_dq_o,
  output logic       sdram_dqoe_o,
  output logic       rd_issued_o
);

  localparam int A10 = 10;

  sched_state_e state_q;
  sched_state_e state_d;
  sdram_cmd_e   cmd_d;
  ba_t          ba_d;
  addr_t        addr_d;
  logic         any_open;
  logic         all_rp_done;
  logic         open_ras_done;
  logic         row_hit;
  logic         req_vld;

  assign any_open      = |bank.bank_open;
  assign all_rp_done   = &bank.rp_done;
  // Every open bank may be precharged
  assign open_ras_done = &(bank.ras_done | ~bank.bank_open);
  assign row_hit       = bank.bank_open[ba_i] && (bank.open_row[ba_i] == row_i);
  // Request is already served while its ack is out
  assign req_vld       = req_i & ~ack_o;

  //////////////////////////////////////////////////
  // Next command
  //////////////////////////////////////////////////
  always_comb
  begin
    state_d = state_q;
    cmd_d   = NOP;
    ba_d    = ba_i;
    addr_d  = '0;
    case (state_q)
      ST_IDLE:
        if (ref_pending_i)
        begin
          // Refresh first, host waits
          if (bank.rc_done)
          begin
            if (any_open)
            begin
              if (open_ras_done)
              begin
                cmd_d       = PRE;
                addr_d[A10] = 1'b1;
                state_d     = ST_REF_PRE;
              end
            end
            else if (all_rp_done)
              cmd_d = REF;
          end
        end
        else if (req_vld)
        begin
          if (row_hit)
          begin
            if (bank.rcd_done[ba_i])
            begin
              cmd_d  = we_i ? WR : RD;
              addr_d = addr_t'(col_i);
            end
          end
          else if (!bank.bank_open[ba_i])
          begin
            // ACT also waits out tRC after a refresh
            if (bank.rp_done[ba_i] && bank.rc_done)
            begin
              cmd_d  = ACT;
              addr_d = row_i;
            end
          end
          else if (bank.ras_done[ba_i])
            cmd_d = PRE;
        end
      ST_REF_PRE:
        if (all_rp_done)
        begin
          cmd_d   = REF;
          state_d = ST_IDLE;
        end
      default: state_d = ST_IDLE;
    endcase
  end

  assign bank.cmd = cmd_d;
  assign bank.ba  = ba_d;
  assign bank.row = addr_d;

  //////////////////////////////////////////////////
  // Pin registers
  //////////////////////////////////////////////////
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      state_q      <= ST_IDLE;
      sdram_cmd_o  <= NOP;
      ack_o        <= 1'b0;
      sdram_dqoe_o <= 1'b0;
      rd_issued_o  <= 1'b0;
      ref_issued_o <= 1'b0;
    end
    else
    begin
      state_q      <= state_d;
      sdram_cmd_o  <= cmd_d;
      ack_o        <= (cmd_d == RD) || (cmd_d == WR);
      sdram_dqoe_o <= (cmd_d == WR);
      rd_issued_o  <= (cmd_d == RD);
      ref_issued_o <= (cmd_d == REF);
    end
  end

  always_ff @(posedge clk_i)
  begin
    sdram_ba_o   <= ba_d;
    sdram_addr_o <= addr_d;
    if (cmd_d == WR)
      sdram_dq_o <= wdata_i;
  end

endmodule

//--- source/rd_data_pipe.sv
// Read data return
// CAS latency shift pipeline that marks and captures returning read data
`timescale 1ns/10ps
`include "sdram_timing_macros.svh"

module rd_data_pipe
  import sdram_dev_pkg::*;
(
  input  logic clk_i,
  input  logic rst_ni,
  input  logic rd_issued_i,
  input  dq_t  sdram_dq_i,
  output logic rvalid_o,
  output dq_t  rdata_o
);

  localparam int CL = `SDRAM_CL;

  // Bit k is set k+1 cycles after RD, top bit is the valid flag itself
  logic [CL:0] vld_q;

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      vld_q <= '0;
    else
      vld_q <= {vld_q[CL-1:0], rd_issued_i};
  end

  // DQ holds the read word CL cycles after RD
  always_ff @(posedge clk_i)
  begin
    if (vld_q[CL-1])
      rdata_o <= sdram_dq_i;
  end

  assign rvalid_o = vld_q[CL];

endmodule

//--- source/refresh_timer.sv
// Refresh timer
// Interval counter with a saturating count of refreshes still owed
`timescale 1ns/10ps
`include "sdram_timing_macros.svh"

module refresh_timer
(
  input  logic clk_i,
  input  logic rst_ni,
  input  logic ref_issued_i,
  output logic ref_pending_o
);

  localparam int REFI_W = $clog2(`SDRAM_T_REFI);
  localparam int PEND_W = $clog2(`SDRAM_REF_PEND_MAX + 1);

  logic [REFI_W-1:0] interval_q;
  logic [PEND_W-1:0] pend_q;
  logic              expire;
  logic              pend_up;
  logic              pend_dn;

  assign expire = (interval_q == '0);

  // Period of SDRAM_T_REFI cycles
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      interval_q <= REFI_W'(`SDRAM_T_REFI - 1);
    else if (expire)
      interval_q <= REFI_W'(`SDRAM_T_REFI - 1);
    else
      interval_q <= interval_q - 1'b1;
  end

  assign pend_up = expire & (pend_q != PEND_W'(`SDRAM_REF_PEND_MAX));
  assign pend_dn = ref_issued_i & (pend_q != '0);

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      pend_q <= '0;
    else
      case ({pend_up, pend_dn})
        2'b10:   pend_q <= pend_q + 1'b1;
        2'b01:   pend_q <= pend_q - 1'b1;
        default: ;
      endcase
  end

  assign ref_pending_o = (pend_q != '0);

endmodule

//--- source/sdram_dev_pkg.sv
// SDRAM device side types
// Command encoding on the pins and the bank, row, column and data vectors
`include "sdram_timing_macros.svh"

package sdram_dev_pkg;

  // Command word on the pins
  typedef enum logic [2:0] {
    NOP = 3'd0,
    ACT = 3'd1,
    RD  = 3'd2,
    WR  = 3'd3,
    PRE = 3'd4,
    REF = 3'd5
  } sdram_cmd_e;

  typedef logic [`SDRAM_BA_W-1:0]  ba_t;
  typedef logic [`SDRAM_ROW_W-1:0] row_t;
  typedef logic [`SDRAM_COL_W-1:0] col_t;
  typedef logic [`SDRAM_DQ_W-1:0]  dq_t;

  // Address bus is as wide as a row
  typedef logic [`SDRAM_ROW_W-1:0] addr_t;

endpackage

//--- source/sdram_host_pkg.sv
// Scheduler control types
// FSM states and the bank timer counter vector
`include "sdram_timing_macros.svh"

package sdram_host_pkg;

  // ST_REF_PRE waits out tRP after a precharge-all before REF
  typedef enum logic {
    ST_IDLE    = 1'b0,
    ST_REF_PRE = 1'b1
  } sched_state_e;

  typedef logic [`SDRAM_TMR_W-1:0] tmr_t;

endpackage

//--- source/sdram_sched_top.sv
// SDRAM command scheduler top level
// Connects the tracker, refresh timer, command FSM and read pipe
`timescale 1ns/10ps

module sdram_sched_top
  import sdram_dev_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,

  // Host port
  input  logic       req_i,
  input  logic       we_i,
  input  ba_t        ba_i,
  input  row_t       row_i,
  input  col_t       col_i,
  input  dq_t        wdata_i,
  output logic       ack_o,
  output logic       rvalid_o,
  output dq_t        rdata_o,

  // SDRAM pins
  output sdram_cmd_e sdram_cmd_o,
  output ba_t        sdram_ba_o,
  output addr_t      sdram_addr_o,
  output dq_t        sdram_dq_o,
  output logic       sdram_dqoe_o,
  input  dq_t        sdram_dq_i
);

  logic ref_pending;
  logic ref_issued;
  logic rd_issued;

  bank_if i_bank_if ();

  bank_tracker i_bank_tracker (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .bank   (i_bank_if.tracker)
  );

  refresh_timer i_refresh_timer (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .ref_issued_i  (ref_issued),
    .ref_pending_o (ref_pending)
  );

  cmd_fsm i_cmd_fsm (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_i         (req_i),
    .we_i          (we_i),
    .ba_i          (ba_i),
    .row_i         (row_i),
    .col_i         (col_i),
    .wdata_i       (wdata_i),
    .ack_o         (ack_o),
    .ref_pending_i (ref_pending),
    .ref_issued_o  (ref_issued),
    .bank          (i_bank_if.fsm),
    .sdram_cmd_o   (sdram_cmd_o),
    .sdram_ba_o    (sdram_ba_o),
    .sdram_addr_o  (sdram_addr_o),
    .sdram_dq_o    (sdram_dq_o),
    .sdram_dqoe_o  (sdram_dqoe_o),
    .rd_issued_o   (rd_issued)
  );

  rd_data_pipe i_rd_data_pipe (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .rd_issued_i (rd_issued),
    .sdram_dq_i  (sdram_dq_i),
    .rvalid_o    (rvalid_o),
    .rdata_o     (rdata_o)
  );

endmodule

//--- tests/sdram_sched_chk.sv
// Command timing checker
// Bank timing rules and handshake rules seen on the SDRAM pins
`timescale 1ns/10ps
`include "sdram_timing_macros.svh"

module sdram_sched_chk
  import sdram_dev_pkg::*;
  import sdram_host_pkg::*;
(
  input logic       clk_i,
  input logic       rst_ni,
  input sdram_cmd_e sdram_cmd_o,
  input ba_t        sdram_ba_o,
  input addr_t      sdram_addr_o,
  input logic       ack_o,
  input logic       sdram_dqoe_o
);

  localparam int NB = `SDRAM_BANKS;

  // Cycles since the last ACT and PRE per bank, saturating
  tmr_t since_act [NB];
  tmr_t since_pre [NB];
  int   fail_count;

  initial fail_count = 0;

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      for (int i = 0; i < NB; i++)
      begin
        since_act[i] <= '1;
        since_pre[i] <= '1;
      end
    end
    else
    begin
      for (int i = 0; i < NB; i++)
      begin
        if (sdram_cmd_o == ACT && sdram_ba_o == ba_t'(i))
          since_act[i] <= tmr_t'(1);
        else if (since_act[i] != '1)
          since_act[i] <= since_act[i] + tmr_t'(1);
        // A10 on PRE means all banks
        if (sdram_cmd_o == PRE && (sdram_addr_o[10] || sdram_ba_o == ba_t'(i)))
          since_pre[i] <= tmr_t'(1);
        else if (since_pre[i] != '1)
          since_pre[i] <= since_pre[i] + tmr_t'(1);
      end
    end
  end

  //////////////////////////////////////////////////
  // Per bank timing
  //////////////////////////////////////////////////
  for (genvar b = 0; b < NB; b++)
  begin : g_bank
    a_rcd: assert property (@(posedge clk_i) disable iff (!rst_ni)
      ((sdram_cmd_o == RD || sdram_cmd_o == WR) && sdram_ba_o == ba_t'(b))
      |-> since_act[b] >= tmr_t'(`SDRAM_T_RCD))
    else
    begin
      $error("tRCD violated on bank %0d", b);
      fail_count++;
    end

    a_rp: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (sdram_cmd_o == ACT && sdram_ba_o == ba_t'(b))
      |-> since_pre[b] >= tmr_t'(`SDRAM_T_RP))
    else
    begin
      $error("tRP violated on bank %0d", b);
      fail_count++;
    end

    a_ras: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (sdram_cmd_o == PRE && (sdram_addr_o[10] || sdram_ba_o == ba_t'(b)))
      |-> since_act[b] >= tmr_t'(`SDRAM_T_RAS))
    else
    begin
      $error("tRAS violated on bank %0d", b);
      fail_count++;
    end
  end

  //////////////////////////////////////////////////
  // Handshake and data enable
  //////////////////////////////////////////////////
  a_ack_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ack_o |=> !ack_o)
  else
  begin
    $error("ack_o high for two cycles");
    fail_count++;
  end

  a_dqoe_wr: assert property (@(posedge clk_i) disable iff (!rst_ni)
    sdram_dqoe_o |-> sdram_cmd_o == WR)
  else
  begin
    $error("sdram_dqoe_o high without WR");
    fail_count++;
  end

endmodule

//--- tests/sdram_sched_tb.sv
// SDRAM scheduler testbench
// Behavioral SDRAM model, request table, read data and refresh checks
`timescale 1ns/10ps
`include "sdram_timing_macros.svh"

module sdram_sched_tb
  import sdram_dev_pkg::*;
();

  localparam int CL          = `SDRAM_CL;
  localparam int NB          = `SDRAM_BANKS;
  localparam int ACK_TIMEOUT = 100;
  localparam int IDLE_CYCLES = 1000;

  typedef logic [`SDRAM_BA_W+`SDRAM_ROW_W+`SDRAM_COL_W-1:0] key_t;

  typedef struct packed {
    logic we;
    ba_t  ba;
    row_t row;
    col_t col;
    dq_t  data;
  } entry_t;

  logic       clk_i;
  logic       rst_ni;
  logic       req_i;
  logic       we_i;
  ba_t        ba_i;
  row_t       row_i;
  col_t       col_i;
  dq_t        wdata_i;
  logic       ack_o;
  logic       rvalid_o;
  dq_t        rdata_o;
  sdram_cmd_e sdram_cmd_o;
  ba_t        sdram_ba_o;
  addr_t      sdram_addr_o;
  dq_t        sdram_dq_o;
  logic       sdram_dqoe_o;
  dq_t        sdram_dq_i;

  entry_t table_q [$];
  dq_t    shadow [key_t];
  int     exp_cyc_q [$];
  dq_t    exp_data_q [$];
  int     cyc;
  int     err_count;
  int     timeout_count;
  int     ack_count;
  int     ref_count;

  // SDRAM model state
  logic [NB-1:0] mdl_open;
  row_t          mdl_row [NB];
  dq_t           mdl_mem [key_t];
  dq_t           dq_dly [CL] = '{default: '0};
  logic          rd_now;
  dq_t           rd_word;

  sdram_sched_top i_sdram_sched_top (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_i        (req_i),
    .we_i         (we_i),
    .ba_i         (ba_i),
    .row_i        (row_i),
    .col_i        (col_i),
    .wdata_i      (wdata_i),
    .ack_o        (ack_o),
    .rvalid_o     (rvalid_o),
    .rdata_o      (rdata_o),
    .sdram_cmd_o  (sdram_cmd_o),
    .sdram_ba_o   (sdram_ba_o),
    .sdram_addr_o (sdram_addr_o),
    .sdram_dq_o   (sdram_dq_o),
    .sdram_dqoe_o (sdram_dqoe_o),
    .sdram_dq_i   (sdram_dq_i)
  );

  bind sdram_sched_top sdram_sched_chk i_sdram_sched_chk (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .sdram_cmd_o  (sdram_cmd_o),
    .sdram_ba_o   (sdram_ba_o),
    .sdram_addr_o (sdram_addr_o),
    .ack_o        (ack_o),
    .sdram_dqoe_o (sdram_dqoe_o)
  );

  always #4 clk_i = ~clk_i;

  // Read word reaches DQ CL cycles after RD
  assign sdram_dq_i = dq_dly[CL-1];

  always @(posedge clk_i)
  begin
    dq_dly[0] <= rd_now ? rd_word : '0;
    for (int k = 1; k < CL; k++)
      dq_dly[k] <= dq_dly[k-1];
  end

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("error at %0d ns: %s got 0x%0h, expected 0x%0h", $time, name, got, exp);
      err_count++;
    end
  endtask

  task automatic add_entry(input logic we, input ba_t ba, input row_t row, input col_t col,
                           input dq_t data);
    entry_t e;
    e.we   = we;
    e.ba   = ba;
    e.row  = row;
    e.col  = col;
    e.data = data;
    table_q.push_back(e);
  endtask

  task automatic fill_table();
    add_entry(1'b1, 2'd0, 13'd5,    10'd10,   16'h1111);
    add_entry(1'b0, 2'd0, 13'd5,    10'd10,   16'h0000);
    add_entry(1'b1, 2'd0, 13'd5,    10'd11,   16'h2222);
    // Row misses on bank 0
    add_entry(1'b1, 2'd0, 13'd9,    10'd10,   16'h3333);
    add_entry(1'b0, 2'd0, 13'd5,    10'd10,   16'h0000);
    add_entry(1'b0, 2'd0, 13'd9,    10'd10,   16'h0000);
    // Spread over banks
    add_entry(1'b1, 2'd1, 13'd100,  10'd3,    16'h4444);
    add_entry(1'b1, 2'd2, 13'd7,    10'd1023, 16'h5555);
    add_entry(1'b1, 2'd3, 13'd8191, 10'd0,    16'h6666);
    add_entry(1'b0, 2'd1, 13'd100,  10'd3,    16'h0000);
    add_entry(1'b0, 2'd2, 13'd7,    10'd1023, 16'h0000);
    add_entry(1'b0, 2'd3, 13'd8191, 10'd0,    16'h0000);
    // Never written
    add_entry(1'b0, 2'd2, 13'd8,    10'd5,    16'h0000);
    add_entry(1'b1, 2'd1, 13'd100,  10'd3,    16'h7777);
    add_entry(1'b0, 2'd1, 13'd100,  10'd3,    16'h0000);
    add_entry(1'b0, 2'd0, 13'd5,    10'd11,   16'h0000);
  endtask

  task automatic drive_request(input entry_t e);
    req_i   <= 1'b1;
    we_i    <= e.we;
    ba_i    <= e.ba;
    row_i   <= e.row;
    col_i   <= e.col;
    wdata_i <= e.data;
  endtask

  task automatic wait_ack(input int idx);
    int n;
    n = 0;
    do
    begin
      @(negedge clk_i);
      n++;
    end
    while (!ack_o && n < ACK_TIMEOUT);
    if (!ack_o)
    begin
      $display("error: table entry %0d got no ack_o within %0d cycles", idx, ACK_TIMEOUT);
      timeout_count++;
    end
  endtask

  //////////////////////////////////////////////////
  // Pin monitor sampled mid cycle
  //////////////////////////////////////////////////
  task automatic check_cmd();
    key_t key;
    logic is_rw;
    key   = {ba_i, row_i, col_i};
    is_rw = (sdram_cmd_o == RD) || (sdram_cmd_o == WR);
    compare("ack_o", 32'(ack_o), 32'(is_rw));
    compare("sdram_dqoe_o", 32'(sdram_dqoe_o), 32'(sdram_cmd_o == WR));
    if (ack_o)
    begin
      ack_count++;
      compare("sdram_cmd_o", 32'(sdram_cmd_o), we_i ? 32'(WR) : 32'(RD));
      compare("sdram_ba_o", 32'(sdram_ba_o), 32'(ba_i));
      compare("sdram_addr_o column", 32'(sdram_addr_o[`SDRAM_COL_W-1:0]), 32'(col_i));
      // Bank must hold the requested row since its last ACT
      compare("model bank open", 32'(mdl_open[ba_i]), 32'd1);
      compare("model open row", 32'(mdl_row[ba_i]), 32'(row_i));
      if (we_i)
      begin
        compare("sdram_dq_o", 32'(sdram_dq_o), 32'(wdata_i));
        shadow[key] = wdata_i;
      end
      else
      begin
        exp_data_q.push_back(shadow.exists(key) ? shadow[key] : '0);
        exp_cyc_q.push_back(cyc + CL + 1);
      end
    end
    if (sdram_cmd_o == REF)
    begin
      ref_count++;
      compare("model banks open at REF", 32'(mdl_open), 32'd0);
    end
  endtask

  task automatic check_rdata();
    int  exp_cyc;
    dq_t exp_word;
    if (rvalid_o)
    begin
      if (exp_data_q.size() == 0)
      begin
        $display("error at %0d ns: rvalid_o high with no read outstanding", $time);
        err_count++;
      end
      else
      begin
        exp_cyc  = exp_cyc_q.pop_front();
        exp_word = exp_data_q.pop_front();
        compare("rvalid_o cycle", cyc, exp_cyc);
        compare("rdata_o", 32'(rdata_o), 32'(exp_word));
      end
    end
    else if (exp_cyc_q.size() != 0 && exp_cyc_q[0] <= cyc)
    begin
      $display("error at %0d ns: rvalid_o missing for a read", $time);
      err_count++;
      exp_cyc  = exp_cyc_q.pop_front();
      exp_word = exp_data_q.pop_front();
    end
  endtask

  task automatic update_model();
    key_t key;
    key    = {sdram_ba_o, mdl_row[sdram_ba_o], sdram_addr_o[`SDRAM_COL_W-1:0]};
    rd_now = 1'b0;
    case (sdram_cmd_o)
      ACT:
      begin
        mdl_open[sdram_ba_o] = 1'b1;
        mdl_row[sdram_ba_o]  = sdram_addr_o;
      end
      PRE:
        if (sdram_addr_o[10])
          mdl_open = '0;
        else
          mdl_open[sdram_ba_o] = 1'b0;
      WR:      mdl_mem[key] = sdram_dq_o;
      RD:
      begin
        rd_now  = 1'b1;
        rd_word = mdl_mem.exists(key) ? mdl_mem[key] : '0;
      end
      default: ;
    endcase
  endtask

  always @(negedge clk_i)
  begin
    if (rst_ni)
    begin
      cyc++;
      check_rdata();
      check_cmd();
      update_model();
    end
  end

  initial
  begin
    int n;
    int refs_start;
    int refs_min;
    int chk_fails;
    clk_i         = 1'b0;
    rst_ni        <= 1'b0;
    req_i         <= 1'b0;
    we_i          <= 1'b0;
    ba_i          <= '0;
    row_i         <= '0;
    col_i         <= '0;
    wdata_i       <= '0;
    rd_now        = 1'b0;
    rd_word       = '0;
    mdl_open      = '0;
    cyc           = 0;
    err_count     = 0;
    timeout_count = 0;
    ack_count     = 0;
    ref_count     = 0;
    fill_table();

    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    compare("sdram_cmd_o in reset", 32'(sdram_cmd_o), 32'(NOP));
    compare("ack_o in reset", 32'(ack_o), 32'd0);
    compare("rvalid_o in reset", 32'(rvalid_o), 32'd0);
    compare("sdram_dqoe_o in reset", 32'(sdram_dqoe_o), 32'd0);
    @(posedge clk_i);
    rst_ni <= 1'b1;

    for (int i = 0; i < table_q.size(); i++)
    begin
      @(posedge clk_i);
      drive_request(table_q[i]);
      wait_ack(i);
    end
    @(posedge clk_i);
    req_i <= 1'b0;

    // Let outstanding reads return
    n = 0;
    while (exp_data_q.size() != 0 && n < 4 * CL + 8)
    begin
      @(posedge clk_i);
      n++;
    end
    if (exp_data_q.size() != 0)
    begin
      $display("error: %0d reads never returned rvalid_o", exp_data_q.size());
      timeout_count++;
    end

    // Idle window for refresh
    refs_start = ref_count;
    refs_min   = IDLE_CYCLES / `SDRAM_T_REFI - 1;
    for (int c = 0; c < IDLE_CYCLES; c++)
      @(posedge clk_i);
    if (ref_count - refs_start < refs_min)
    begin
      $display("error: only %0d refreshes in %0d idle cycles, expected at least %0d",
               ref_count - refs_start, IDLE_CYCLES, refs_min);
      err_count++;
    end

    compare("ack_o count", ack_count, table_q.size());
    chk_fails = i_sdram_sched_top.i_sdram_sched_chk.fail_count;
    $display("errors: %0d value, %0d timeout, %0d assertion",
             err_count, timeout_count, chk_fails);
    if (err_count == 0 && timeout_count == 0 && chk_fails == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

endmodule

//--- vlog.f
+incdir+include
source/sdram_dev_pkg.sv
source/sdram_host_pkg.sv
source/bank_if.sv
source/bank_tracker.sv
source/refresh_timer.sv
source/cmd_fsm.sv
source/rd_data_pipe.sv
source/sdram_sched_top.sv
tests/sdram_sched_chk.sv
tests/sdram_sched_tb.sv
